//--- cart_loader.f
snes_cart_pkg.sv
download_decoder.sv
header_parser.sv
cheat_assembler.sv
backup_sequencer.sv
cart_loader.sv
cart_checker.sv
tb_cart_loader.sv

//--- Makefile
# Verilator build, run, lint and clean for the cartridge loader

VERILATOR ?= verilator
TOP       ?= tb_cart_loader
RTL_TOP   ?= cart_loader
FILELIST  ?= cart_loader.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_TEXT ?= Test completed successfully
VFLAGS    ?= --binary --timing -j 0

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_TEXT)" $(LOG)

lint:
	$(VERILATOR) --lint-only -Wall --timing -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- cart_loader_input.txt
// cmd p0 p1 p2 p3 p4 e0 e1 e2 e3 (hex), cmd 1 header 2 code 3 load 4 save 5 xfer 6 write 7 osd
// header: p0 mode, p1 region (bit4 mount, bit5 nonempty), p2 word0, p3 word2, p4 info/ram word
1 0 0 2100 0000 00000000 21 3FFFFF 0 0
1 0 0 3538 0100 00000000 35 3FFFF 1FFF 1
1 1 1 1234 0100 00000000 0 3FFFFF 0 0
1 2 2 00AB 0000 0A000001 0 FFFFF 7FF 1
1 4 1 0000 0100 0D000005 2 7FFFFF 7FFF 0
3 0 0 0 0 0 0 0 0 0
5 0 0 0 0 0 0 0 0 0
2 12345678 9ABCDEF0 0F1E2D3C 4B5A6978 0 12345678 9ABCDEF0 0F1E2D3C 4B5A6978
1 3 30 0000 0100 0B000002 1 1FFFFF FFF 1
5 0 0 0 0 0 8 0 0 0
6 1 0 0 0 0 1 1 0 0
7 1 0 0 0 0 0 0 0 0
5 0 0 0 0 0 0 8 0 0
7 0 0 0 0 0 0 0 0 0
4 0 0 0 0 0 0 0 0 0
5 0 0 0 0 0 0 8 0 0
3 0 0 0 0 0 0 0 0 0
5 0 0 0 0 0 8 0 0 0
0 0 0 0 0 0 0 0 0 0

//--- tb_cart_loader.sv
//==========================================================================
// Cartridge loader testbench
// File-driven stimulus, sd_ack responder and checker hookup
//==========================================================================
`timescale 1ns/100ps
`default_nettype none

module tb_cart_loader;

	localparam int MAX_RECS = 32;
	localparam int FIELDS   = 10;

	logic clk_sys;
	logic reset;
	logic dl_active;
	logic [7:0] dl_index;
	snes_cart_pkg::dl_addr_t dl_addr;
	snes_cart_pkg::dl_data_t dl_data;
	logic dl_wr;
	snes_cart_pkg::header_mode_e header_mode;
	snes_cart_pkg::region_sel_e region_sel;
	logic autosave;
	logic img_mounted;
	logic img_nonempty;
	logic bk_load;
	logic bk_save;
	logic bk_write;
	logic osd_status;
	logic sd_ack;
	logic [7:0] rom_type;
	snes_cart_pkg::mask_t rom_mask;
	snes_cart_pkg::mask_t ram_mask;
	logic pal;
	snes_cart_pkg::cheat_code_t cheat_code;
	logic cheat_valid;
	logic cheat_clear;
	logic [31:0] sd_lba;
	logic sd_rd;
	logic sd_wr;
	logic bk_loading;
	logic bk_pending;
	logic core_hold;
	logic led_user;

	logic mark;
	logic check_req;
	logic [2:0] check_kind;
	logic [31:0] exp0;
	logic [31:0] exp1;
	logic [31:0] exp2;
	logic [31:0] exp3;
	logic finish_req;
	logic [7:0] timeouts;
	logic [15:0] error_count;

	logic [31:0] recs [0:MAX_RECS*FIELDS-1];
	logic [15:0] lfsr_state;
	logic [1:0] ack_state;
	int ack_wait;

	cart_loader u_dut (.*);

	cart_checker u_checker (.*);

	initial begin
		clk_sys = 1'b0;
		forever #50 clk_sys = ~clk_sys;
	end

	//======================================================================
	// sd_ack responder with random delays
	//======================================================================
	// Fibonacci LFSR with taps at x^16, x^14, x^13 and x^11
	task automatic draw_delay(output int d);
		logic fb;
		d = 0;
		for (int i = 0; i < 3; i++) begin
			fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
			lfsr_state = {lfsr_state[14:0], fb};
			d = (d << 1) | int'(fb);
		end
		d = d + 1;
	endtask

	initial begin
		sd_ack    = 1'b0;
		ack_state = 2'd0;
		ack_wait  = 0;
		forever begin
			@(posedge clk_sys);
			if (!reset) begin
				sd_ack    <= 1'b0;
				ack_state = 2'd0;
				ack_wait  = 0;
			end else begin
				case (ack_state)
					2'd0: if (sd_rd || sd_wr) begin
						draw_delay(ack_wait);
						ack_state = 2'd1;
					end
					2'd1: if (ack_wait > 1) begin
						ack_wait = ack_wait - 1;
					end else begin
						sd_ack <= 1'b1;
						draw_delay(ack_wait);
						ack_state = 2'd2;
					end
					default: if (ack_wait > 1) begin
						ack_wait = ack_wait - 1;
					end else begin
						sd_ack    <= 1'b0;
						ack_state = 2'd0;
					end
				endcase
			end
		end
	end

	//======================================================================
	// Stimulus helpers
	//======================================================================
	task automatic write_word(input logic [24:0] addr, input logic [15:0] data);
		@(posedge clk_sys);
		dl_addr <= addr;
		dl_data <= data;
		dl_wr   <= 1'b1;
		@(posedge clk_sys);
		dl_wr <= 1'b0;
	endtask

	task automatic pulse_mark();
		@(posedge clk_sys);
		mark <= 1'b1;
		@(posedge clk_sys);
		mark <= 1'b0;
	endtask

	task automatic request_check(input logic [2:0] kind, input logic [31:0] e0,
		input logic [31:0] e1, input logic [31:0] e2, input logic [31:0] e3);
		@(posedge clk_sys);
		check_req  <= 1'b1;
		check_kind <= kind;
		exp0 <= e0;
		exp1 <= e1;
		exp2 <= e2;
		exp3 <= e3;
		@(posedge clk_sys);
		check_req <= 1'b0;
	endtask

	// Transfer is over once bk_loading, requests and sd_ack stay low
	task automatic wait_quiet();
		int quiet;
		int cycles;
		quiet  = 0;
		cycles = 0;
		while (quiet < 24 && cycles < 5000) begin
			@(posedge clk_sys);
			cycles++;
			quiet = (sd_rd || sd_wr || sd_ack || bk_loading) ? 0 : quiet + 1;
		end
		if (quiet < 24) begin
			$display("Timeout: sector transfer did not finish at %0t", $time);
			timeouts = timeouts + 8'd1;
		end
	endtask

	task automatic run_header(input int b);
		logic [24:0] info;
		case (recs[b+1][2:0])
			3'd3:    info = 25'h000FFD6 + 25'd512;
			3'd4:    info = 25'h040FFD6 + 25'd512;
			default: info = 25'h0007FD6 + 25'd512;
		endcase
		pulse_mark();
		@(posedge clk_sys);
		header_mode  <= snes_cart_pkg::header_mode_e'(recs[b+1][2:0]);
		region_sel   <= snes_cart_pkg::region_sel_e'(recs[b+2][1:0]);
		img_nonempty <= recs[b+2][5];
		dl_index     <= 8'h01;
		dl_active    <= 1'b1;
		write_word(25'd0, recs[b+3][15:0]);
		write_word(25'd2, recs[b+4][15:0]);
		write_word(info, recs[b+5][31:16]);
		write_word(info + 25'd2, recs[b+5][15:0]);
		// Save image arrives while the cartridge is still loading
		if (recs[b+2][4]) begin
			@(posedge clk_sys);
			img_mounted <= 1'b1;
			@(posedge clk_sys);
			img_mounted <= 1'b0;
		end
		@(posedge clk_sys);
		dl_active <= 1'b0;
		repeat (2) @(posedge clk_sys);
		request_check(3'd0, recs[b+6], recs[b+7], recs[b+8], recs[b+9]);
	endtask

	task automatic run_code(input int b);
		pulse_mark();
		@(posedge clk_sys);
		dl_index  <= 8'hFF;
		dl_active <= 1'b1;
		for (int i = 0; i < 4; i++) begin
			write_word(25'(i * 4), recs[b+1+i][15:0]);
			write_word(25'(i * 4 + 2), recs[b+1+i][31:16]);
		end
		@(posedge clk_sys);
		dl_active <= 1'b0;
		request_check(3'd1, recs[b+6], recs[b+7], recs[b+8], recs[b+9]);
	endtask

	//======================================================================
	// Main sequence
	//======================================================================
	initial begin
		logic stop;
		int b;
		reset = 1'b0;
		dl_active = 1'b0;
		dl_index = 8'h00;
		dl_addr = '0;
		dl_data = '0;
		dl_wr = 1'b0;
		header_mode = snes_cart_pkg::HDR_AUTO;
		region_sel = snes_cart_pkg::REGION_AUTO;
		autosave = 1'b0;
		img_mounted = 1'b0;
		img_nonempty = 1'b0;
		bk_load = 1'b0;
		bk_save = 1'b0;
		bk_write = 1'b0;
		osd_status = 1'b0;
		mark = 1'b0;
		check_req = 1'b0;
		check_kind = 3'd0;
		exp0 = '0;
		exp1 = '0;
		exp2 = '0;
		exp3 = '0;
		finish_req = 1'b0;
		timeouts = 8'd0;
		lfsr_state = 16'd52749;
		$readmemh("cart_loader_input.txt", recs);
		repeat (10) @(posedge clk_sys);
		reset <= 1'b1;
		repeat (2) @(posedge clk_sys);

		stop = 1'b0;
		for (int r = 0; r < MAX_RECS && !stop; r++) begin
			b = r * FIELDS;
			case (recs[b])
				32'd1: run_header(b);
				32'd2: run_code(b);
				32'd3, 32'd4: begin
					pulse_mark();
					@(posedge clk_sys);
					if (recs[b] == 32'd3) begin
						bk_load <= 1'b1;
					end else begin
						bk_save <= 1'b1;
					end
					repeat (2) @(posedge clk_sys);
					bk_load <= 1'b0;
					bk_save <= 1'b0;
				end
				32'd5: begin
					wait_quiet();
					request_check(3'd2, recs[b+6], recs[b+7], recs[b+8], 32'd0);
				end
				32'd6: begin
					@(posedge clk_sys);
					autosave <= recs[b+1][0];
					bk_write <= 1'b1;
					@(posedge clk_sys);
					bk_write <= 1'b0;
					request_check(3'd3, recs[b+6], recs[b+7], 32'd0, 32'd0);
				end
				32'd7: begin
					pulse_mark();
					@(posedge clk_sys);
					osd_status <= recs[b+1][0];
				end
				default: stop = 1'b1;
			endcase
		end

		repeat (4) @(posedge clk_sys);
		finish_req <= 1'b1;
		@(posedge clk_sys);
		finish_req <= 1'b0;
		repeat (2) @(posedge clk_sys);
		if (error_count == 16'd0 && timeouts == 8'd0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- cart_checker.sv
//==========================================================================
// Cartridge loader checker
// Watches the DUT ports, counts sector requests and compares results
//==========================================================================
`timescale 1ns/100ps
`default_nettype none

module cart_checker (
	input  wire logic                       clk_sys,
	input  wire logic                       reset,
	input  wire logic [7:0]                 rom_type,
	input  wire snes_cart_pkg::mask_t        rom_mask,
	input  wire snes_cart_pkg::mask_t        ram_mask,
	input  wire logic                       pal,
	input  wire snes_cart_pkg::cheat_code_t  cheat_code,
	input  wire logic                       cheat_valid,
	input  wire logic                       cheat_clear,
	input  wire logic [31:0]                sd_lba,
	input  wire logic                       sd_rd,
	input  wire logic                       sd_wr,
	input  wire logic                       bk_loading,
	input  wire logic                       bk_pending,
	input  wire logic                       core_hold,
	input  wire logic                       led_user,
	input  wire logic                       mark,
	input  wire logic                       check_req,
	input  wire logic [2:0]                 check_kind,
	input  wire logic [31:0]                exp0,
	input  wire logic [31:0]                exp1,
	input  wire logic [31:0]                exp2,
	input  wire logic [31:0]                exp3,
	input  wire logic                       finish_req,
	input  wire logic [7:0]                 timeouts,
	output logic [15:0]                     error_count
);

	logic        rd_q;
	logic        wr_q;
	logic        test_bad;
	logic        clear_seen;
	int unsigned rd_count;
	int unsigned wr_count;
	int unsigned valid_count;
	int unsigned test_count;
	int unsigned fail_count;

	task automatic compare_value(input string what, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp) begin
			$display("ERR %0t: %s got %h expected %h", $time, what, got, exp);
			error_count = error_count + 16'd1;
			test_bad = 1'b1;
		end
	endtask

	task automatic run_check();
		string name;
		name = "status";
		case (check_kind)
			3'd0: begin
				name = "header";
				compare_value("rom_type", 32'(rom_type), exp0);
				compare_value("rom_mask", 32'(rom_mask), exp1);
				compare_value("ram_mask", 32'(ram_mask), exp2);
				compare_value("pal", 32'(pal), exp3);
				compare_value("cheat_clear seen", 32'(clear_seen), 32'd1);
			end
			3'd1: begin
				name = "cheat";
				compare_value("flags", cheat_code.flags, exp0);
				compare_value("address", cheat_code.address, exp1);
				compare_value("compare", cheat_code.compare, exp2);
				compare_value("replace", cheat_code.replace, exp3);
				compare_value("cheat_valid pulses", valid_count, 32'd1);
				compare_value("cheat_clear seen", 32'(clear_seen), 32'd1);
			end
			3'd2: begin
				name = "transfer";
				compare_value("read sectors", rd_count, exp0);
				compare_value("write sectors", wr_count, exp1);
				compare_value("bk_pending", 32'(bk_pending), exp2);
				compare_value("core_hold after transfer", 32'(core_hold), 32'd0);
			end
			default: begin
				compare_value("bk_pending", 32'(bk_pending), exp0);
				compare_value("led_user", 32'(led_user), exp1);
			end
		endcase
		test_count = test_count + 1;
		if (test_bad) begin
			fail_count = fail_count + 1;
			$display("test %0d %s: FAILED", test_count, name);
		end else begin
			$display("test %0d %s: ok", test_count, name);
		end
		test_bad = 1'b0;
	endtask

	always @(posedge clk_sys) begin
		if (!reset) begin
			rd_q        = 1'b0;
			wr_q        = 1'b0;
			test_bad    = 1'b0;
			clear_seen  = 1'b0;
			rd_count    = 0;
			wr_count    = 0;
			valid_count = 0;
			test_count  = 0;
			fail_count  = 0;
			error_count = 16'd0;
		end else begin
			if (mark) begin
				rd_count    = 0;
				wr_count    = 0;
				valid_count = 0;
				clear_seen  = 1'b0;
			end
			// Each new request carries the next sector number
			if (sd_rd && !rd_q) begin
				compare_value("read lba", sd_lba, rd_count + wr_count);
				compare_value("core_hold on read", 32'(core_hold), 32'd1);
				compare_value("bk_loading on read", 32'(bk_loading), 32'd1);
				rd_count = rd_count + 1;
			end
			if (sd_wr && !wr_q) begin
				compare_value("write lba", sd_lba, rd_count + wr_count);
				compare_value("bk_loading on write", 32'(bk_loading), 32'd0);
				wr_count = wr_count + 1;
			end
			if (sd_rd && sd_wr) begin
				$display("ERR %0t: read and write requested together", $time);
				error_count = error_count + 16'd1;
				test_bad = 1'b1;
			end
			if (cheat_valid) begin
				valid_count = valid_count + 1;
			end
			if (cheat_clear) begin
				clear_seen = 1'b1;
			end
			if (check_req) begin
				run_check();
			end
			if (finish_req) begin
				$display("tests %0d, failed %0d, errors %0d, timeouts %0d",
					test_count, fail_count, error_count, timeouts);
			end
			rd_q = sd_rd;
			wr_q = sd_wr;
		end
	end

endmodule

`default_nettype wire

//--- cart_loader.sv
//==========================================================================
// Cartridge load controller
// Download decoding, header parsing, cheat records and backup RAM
// transfers for the console core
//==========================================================================
`timescale 1ns/100ps
`default_nettype none

module cart_loader #(
	parameter int unsigned COPIER_HEADER_BYTES = 512,
	parameter int unsigned SECTOR_BITS         = 9
) (
	input  wire logic                       clk_sys,
	input  wire logic                       reset,
	// Download stream
	input  wire logic                       dl_active,
	input  wire logic [7:0]                 dl_index,
	input  wire snes_cart_pkg::dl_addr_t     dl_addr,
	input  wire snes_cart_pkg::dl_data_t     dl_data,
	input  wire logic                       dl_wr,
	// Menu settings
	input  wire snes_cart_pkg::header_mode_e header_mode,
	input  wire snes_cart_pkg::region_sel_e  region_sel,
	input  wire logic                       autosave,
	// Save image and backup control
	input  wire logic                       img_mounted,
	input  wire logic                       img_nonempty,
	input  wire logic                       bk_load,
	input  wire logic                       bk_save,
	input  wire logic                       bk_write,
	input  wire logic                       osd_status,
	input  wire logic                       sd_ack,
	// Cartridge configuration
	output logic [7:0]                      rom_type,
	output snes_cart_pkg::mask_t            rom_mask,
	output snes_cart_pkg::mask_t            ram_mask,
	output logic                            pal,
	// Cheats
	output snes_cart_pkg::cheat_code_t      cheat_code,
	output logic                            cheat_valid,
	output logic                            cheat_clear,
	// Sector requests and status
	output logic [31:0]                     sd_lba,
	output logic                            sd_rd,
	output logic                            sd_wr,
	output logic                            bk_loading,
	output logic                            bk_pending,
	output logic                            core_hold,
	output logic                            led_user
);

	logic cart_dl;
	logic code_dl;
	logic cart_start;
	logic cart_end;

	download_decoder u_download_decoder (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.dl_active  (dl_active),
		.dl_index   (dl_index),
		.cart_dl    (cart_dl),
		.code_dl    (code_dl),
		.cart_start (cart_start),
		.cart_end   (cart_end)
	);

	header_parser #(
		.COPIER_HEADER_BYTES (COPIER_HEADER_BYTES)
	) u_header_parser (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.cart_dl     (cart_dl),
		.dl_wr       (dl_wr),
		.dl_addr     (dl_addr),
		.dl_data     (dl_data),
		.header_mode (header_mode),
		.region_sel  (region_sel),
		.rom_type    (rom_type),
		.rom_mask    (rom_mask),
		.ram_mask    (ram_mask),
		.pal         (pal)
	);

	cheat_assembler u_cheat_assembler (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.code_dl     (code_dl),
		.cart_dl     (cart_dl),
		.dl_wr       (dl_wr),
		.dl_addr     (dl_addr),
		.dl_data     (dl_data),
		.cheat_code  (cheat_code),
		.cheat_valid (cheat_valid),
		.cheat_clear (cheat_clear)
	);

	backup_sequencer #(
		.SECTOR_BITS (SECTOR_BITS)
	) u_backup_sequencer (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.cart_dl      (cart_dl),
		.cart_start   (cart_start),
		.cart_end     (cart_end),
		.ram_mask     (ram_mask),
		.img_mounted  (img_mounted),
		.img_nonempty (img_nonempty),
		.bk_load      (bk_load),
		.bk_save      (bk_save),
		.autosave     (autosave),
		.bk_write     (bk_write),
		.osd_status   (osd_status),
		.sd_ack       (sd_ack),
		.sd_lba       (sd_lba),
		.sd_rd        (sd_rd),
		.sd_wr        (sd_wr),
		.bk_loading   (bk_loading),
		.bk_pending   (bk_pending),
		.core_hold    (core_hold),
		.led_user     (led_user)
	);

endmodule

`default_nettype wire

//--- backup_sequencer.sv
//==========================================================================
// Backup RAM sequencer
// Tracks backup enable and unsaved writes and runs the sector transfers
// between battery RAM and the save image
//==========================================================================
`timescale 1ns/100ps
`default_nettype none

module backup_sequencer #(
	parameter int unsigned SECTOR_BITS = 9
) (
	input  wire logic                clk_sys,
	input  wire logic                reset,
	input  wire logic                cart_dl,
	input  wire logic                cart_start,
	input  wire logic                cart_end,
	input  wire snes_cart_pkg::mask_t ram_mask,
	input  wire logic                img_mounted,
	input  wire logic                img_nonempty,
	input  wire logic                bk_load,
	input  wire logic                bk_save,
	input  wire logic                autosave,
	input  wire logic                bk_write,
	input  wire logic                osd_status,
	input  wire logic                sd_ack,
	output logic [31:0]              sd_lba,
	output logic                     sd_rd,
	output logic                     sd_wr,
	output logic                     bk_loading,
	output logic                     bk_pending,
	output logic                     core_hold,
	output logic                     led_user
);

	logic        bk_ena;
	logic        bk_busy;
	logic        load_q;
	logic        save_q;
	logic        ack_q;
	logic        save_req;
	logic        start_rd;
	logic        start_wr;
	logic [31:0] last_lba;

	//======================================================================
	// Backup enable and pending writes
	//======================================================================
	always_ff @(posedge clk_sys) begin
		if (!reset) begin
			bk_ena <= 1'b0;
		end else begin
			if (cart_start) begin
				bk_ena <= 1'b0;
			end
			// Save image is mounted while the cartridge is still loading
			if (cart_dl && img_mounted) begin
				bk_ena <= |ram_mask;
			end
		end
	end

	always_ff @(posedge clk_sys) begin
		if (!reset) begin
			bk_pending <= 1'b0;
		end else if (bk_ena && !osd_status && bk_write) begin
			bk_pending <= 1'b1;
		end else if (bk_busy) begin
			bk_pending <= 1'b0;
		end
	end

	//======================================================================
	// Transfer triggers
	//======================================================================
	// Autosave fires once the menu opens over unsaved data
	assign save_req = bk_save | (bk_pending & osd_status & autosave);

	assign start_rd = bk_ena & ((bk_load & ~load_q) | (cart_end & img_nonempty));
	assign start_wr = bk_ena & save_req & ~save_q;

	// Last sector number of the RAM image
	assign last_lba = 32'(ram_mask >> SECTOR_BITS);

	always_ff @(posedge clk_sys) begin
		if (!reset) begin
			load_q     <= 1'b0;
			save_q     <= 1'b0;
			ack_q      <= 1'b0;
			bk_busy    <= 1'b0;
			bk_loading <= 1'b0;
			sd_rd      <= 1'b0;
			sd_wr      <= 1'b0;
			sd_lba     <= 32'd0;
		end else begin
			load_q <= bk_load;
			save_q <= save_req;
			ack_q  <= sd_ack;

			// Host took the request
			if (sd_ack && !ack_q) begin
				sd_rd <= 1'b0;
				sd_wr <= 1'b0;
			end

			if (!bk_busy) begin
				if (start_rd) begin
					bk_busy    <= 1'b1;
					bk_loading <= 1'b1;
					sd_lba     <= 32'd0;
					sd_rd      <= 1'b1;
					sd_wr      <= 1'b0;
				end else if (start_wr) begin
					bk_busy    <= 1'b1;
					bk_loading <= 1'b0;
					sd_lba     <= 32'd0;
					sd_rd      <= 1'b0;
					sd_wr      <= 1'b1;
				end
			end else if (!sd_ack && ack_q) begin
				// Sector done, finish or move on
				if (sd_lba >= last_lba) begin
					bk_busy    <= 1'b0;
					bk_loading <= 1'b0;
				end else begin
					sd_lba <= sd_lba + 32'd1;
					sd_rd  <= bk_loading;
					sd_wr  <= ~bk_loading;
				end
			end
		end
	end

	// Core stays held while RAM contents are replaced
	assign core_hold = cart_dl | bk_loading;
	assign led_user  = cart_dl | (autosave & bk_pending);

endmodule

`default_nettype wire

//--- cheat_assembler.sv
//==========================================================================
// Cheat record assembler
// Builds one 128-bit cheat record from eight download words and strobes
// it into the core, with a clear request for the cheat engine
//==========================================================================
`timescale 1ns/100ps
`default_nettype none

module cheat_assembler (
	input  wire logic                   clk_sys,
	input  wire logic                   reset,
	input  wire logic                   code_dl,
	input  wire logic                   cart_dl,
	input  wire logic                   dl_wr,
	input  wire snes_cart_pkg::dl_addr_t dl_addr,
	input  wire snes_cart_pkg::dl_data_t dl_data,
	output snes_cart_pkg::cheat_code_t  cheat_code,
	output logic                        cheat_valid,
	output logic                        cheat_clear
);

	logic code_wr;
	logic clear_q;

	assign code_wr = code_dl & dl_wr;

	// Field halves, low word first within each field
	always_ff @(posedge clk_sys) begin
		if (code_wr) begin
			case (dl_addr[3:0])
				4'd0:  cheat_code.flags[15:0]    <= dl_data;
				4'd2:  cheat_code.flags[31:16]   <= dl_data;
				4'd4:  cheat_code.address[15:0]  <= dl_data;
				4'd6:  cheat_code.address[31:16] <= dl_data;
				4'd8:  cheat_code.compare[15:0]  <= dl_data;
				4'd10: cheat_code.compare[31:16] <= dl_data;
				4'd12: cheat_code.replace[15:0]  <= dl_data;
				4'd14: cheat_code.replace[31:16] <= dl_data;
				default: ;
			endcase
		end
	end

	// Top replace word closes the record
	always_ff @(posedge clk_sys) begin
		if (!reset) begin
			cheat_valid <= 1'b0;
			clear_q     <= 1'b0;
		end else begin
			cheat_valid <= code_wr & (dl_addr[3:0] == 4'd14);
			clear_q     <= code_wr & (dl_addr == '0);
		end
	end

	// First code word of a new list, or any cartridge load
	assign cheat_clear = cart_dl | clear_q;

endmodule

`default_nettype wire

//--- header_parser.sv
//==========================================================================
// ROM header parser
// Picks mapper type, ROM and RAM sizes and region out of the copier and
// internal headers and derives the address masks and the video standard
//==========================================================================
`timescale 1ns/100ps
`default_nettype none

module header_parser #(
	parameter int unsigned COPIER_HEADER_BYTES = 512
) (
	input  wire logic                       clk_sys,
	input  wire logic                       reset,
	input  wire logic                       cart_dl,
	input  wire logic                       dl_wr,
	input  wire snes_cart_pkg::dl_addr_t     dl_addr,
	input  wire snes_cart_pkg::dl_data_t     dl_data,
	input  wire snes_cart_pkg::header_mode_e header_mode,
	input  wire snes_cart_pkg::region_sel_e  region_sel,
	output logic [7:0]                      rom_type,
	output snes_cart_pkg::mask_t            rom_mask,
	output snes_cart_pkg::mask_t            ram_mask,
	output logic                            pal
);

	localparam snes_cart_pkg::dl_addr_t HDR_OFS =
		snes_cart_pkg::dl_addr_t'(COPIER_HEADER_BYTES);

	logic [3:0]              rom_size;
	logic [3:0]              ram_size;
	logic                    rom_region;
	logic                    hdr_wr;
	logic                    info_hit;
	snes_cart_pkg::dl_addr_t info_addr;
	snes_cart_pkg::dl_addr_t ram_info_addr;

	assign hdr_wr = cart_dl & dl_wr;

	// Where the size words live for the forced mapper modes
	always_comb begin
		info_hit  = 1'b1;
		info_addr = '0;
		case (header_mode)
			snes_cart_pkg::HDR_LOROM:   info_addr = snes_cart_pkg::LOROM_INFO + HDR_OFS;
			snes_cart_pkg::HDR_HIROM:   info_addr = snes_cart_pkg::HIROM_INFO + HDR_OFS;
			snes_cart_pkg::HDR_EXHIROM: info_addr = snes_cart_pkg::EXHIROM_INFO + HDR_OFS;
			default:                    info_hit  = 1'b0;
		endcase
	end

	assign ram_info_addr = info_addr + 25'd2;

	//======================================================================
	// Size, type and region capture
	//======================================================================
	always_ff @(posedge clk_sys) begin
		if (!reset) begin
			rom_size   <= 4'hC;
			ram_size   <= 4'h0;
			rom_type   <= 8'h00;
			rom_region <= 1'b0;
		end else if (hdr_wr) begin
			if (dl_addr == '0) begin
				rom_size <= 4'hC;
				ram_size <= 4'h0;
				// Copier header byte packs both sizes
				if (header_mode == snes_cart_pkg::HDR_AUTO && dl_data[7:0] != 8'h00) begin
					ram_size <= dl_data[7:4];
					rom_size <= dl_data[3:0];
				end
				case (header_mode)
					snes_cart_pkg::HDR_NO_HEADER: rom_type <= 8'd0;
					snes_cart_pkg::HDR_LOROM:     rom_type <= 8'd0;
					snes_cart_pkg::HDR_HIROM:     rom_type <= 8'd1;
					snes_cart_pkg::HDR_EXHIROM:   rom_type <= 8'd2;
					default:                      rom_type <= dl_data[15:8];
				endcase
			end

			if (dl_addr == 25'd2) begin
				rom_region <= dl_data[8];
			end

			// Internal header, only for a forced mapper
			if (info_hit) begin
				if (dl_addr == info_addr) begin
					rom_size <= dl_data[11:8];
				end
				if (dl_addr == ram_info_addr) begin
					ram_size <= dl_data[3:0];
				end
			end
		end
	end

	// Masks follow the size registers directly
	assign rom_mask = (24'd1024 << rom_size) - 24'd1;
	assign ram_mask = (ram_size == 4'h0) ? 24'd0 : (24'd1024 << ram_size) - 24'd1;

	// Video standard, frozen while a cartridge loads
	always_ff @(posedge clk_sys) begin
		if (!reset) begin
			pal <= 1'b0;
		end else if (!cart_dl) begin
			if (region_sel == snes_cart_pkg::REGION_AUTO) begin
				pal <= rom_region;
			end else begin
				pal <= (region_sel == snes_cart_pkg::REGION_PAL);
			end
		end
	end

endmodule

`default_nettype wire

//--- download_decoder.sv
//==========================================================================
// Download stream decoder
// Splits the download into cartridge and cheat traffic and marks the
// start and end of a cartridge download
//==========================================================================
`timescale 1ns/100ps
`default_nettype none

module download_decoder (
	input  wire logic       clk_sys,
	input  wire logic       reset,
	input  wire logic       dl_active,
	input  wire logic [7:0] dl_index,
	output logic            cart_dl,
	output logic            code_dl,
	output logic            cart_start,
	output logic            cart_end
);

	logic code_index;
	logic cart_dl_q;

	// Cheat data uses the all-ones index, everything else is a cartridge
	assign code_index = (dl_index == snes_cart_pkg::CODE_INDEX);
	assign cart_dl    = dl_active & ~code_index;
	assign code_dl    = dl_active & code_index;

	// Edge pulses, one cycle behind the level
	always_ff @(posedge clk_sys) begin
		if (!reset) begin
			cart_dl_q  <= 1'b0;
			cart_start <= 1'b0;
			cart_end   <= 1'b0;
		end else begin
			cart_dl_q  <= cart_dl;
			cart_start <= cart_dl & ~cart_dl_q;
			cart_end   <= ~cart_dl & cart_dl_q;
		end
	end

endmodule

`default_nettype wire

//--- snes_cart_pkg.sv
//==========================================================================
// Cartridge loader shared definitions
// Download word types, internal header offsets, header and region
// selection encodings and the cheat record layout
//==========================================================================
`default_nettype none

package snes_cart_pkg;

	// Download stream
	typedef logic [24:0] dl_addr_t;
	typedef logic [15:0] dl_data_t;

	// ROM and RAM address masks
	typedef logic [23:0] mask_t;

	// Index reserved for cheat code downloads
	localparam logic [7:0] CODE_INDEX = 8'hFF;

	// ROM header selection from the menu
	typedef enum logic [2:0] {
		HDR_AUTO      = 3'd0,
		HDR_NO_HEADER = 3'd1,
		HDR_LOROM     = 3'd2,
		HDR_HIROM     = 3'd3,
		HDR_EXHIROM   = 3'd4
	} header_mode_e;

	// Video region selection
	typedef enum logic [1:0] {
		REGION_AUTO = 2'd0,
		REGION_NTSC = 2'd1,
		REGION_PAL  = 2'd2
	} region_sel_e;

	// ROM size word of the internal header, before the copier header
	// RAM size word sits 2 bytes above
	localparam dl_addr_t LOROM_INFO   = 25'h0007FD6;
	localparam dl_addr_t HIROM_INFO   = 25'h000FFD6;
	localparam dl_addr_t EXHIROM_INFO = 25'h040FFD6;

	// One cheat record, top field first
	typedef struct packed {
		logic [31:0] flags;
		logic [31:0] address;
		logic [31:0] compare;
		logic [31:0] replace;
	} cheat_code_t;

endpackage

`default_nettype wire
